//--- all.f
logic/alu_pkg.sv
logic/alu_sequencer.sv
logic/alu_datapath.sv
logic/alu_top.sv
sim/alu_assert.sv
sim/alu_tb.sv

//--- sim/alu_tb.sv
// Table-driven ALU testbench checking results, latency and back-pressure
`timescale 1ns/100ps
`default_nettype none

module alu_tb;
  import alu_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int FIXED_ROWS   = 8;
  localparam int NUM_ROWS     = 24;
  localparam int ROW_CYCLES   = 40;  // Upper bound for one operation incl. back-pressure

  logic                  clk;
  logic                  rst_n;
  logic [DATA_WIDTH-1:0] a;
  logic [DATA_WIDTH-1:0] b;
  logic [OP_WIDTH-1:0]   op;
  logic                  valid;
  logic                  ready;
  logic [DATA_WIDTH-1:0] result;
  logic                  error;
  logic                  result_valid;
  logic                  result_ready;

  // Stimulus and expected values for each operation
  logic [DATA_WIDTH-1:0] tab_a       [NUM_ROWS];
  logic [DATA_WIDTH-1:0] tab_b       [NUM_ROWS];
  logic [OP_WIDTH-1:0]   tab_op      [NUM_ROWS];
  logic [DATA_WIDTH-1:0] tab_result  [NUM_ROWS];
  bit                    tab_error   [NUM_ROWS];
  int                    tab_latency [NUM_ROWS];
  int                    tab_hold    [NUM_ROWS];  // Cycles of back-pressure

  int     row_count  = 0;
  int     errors     = 0;
  int     pass_count = 0;
  int     fail_count = 0;
  integer seed       = 32'h3441_ec2c;

  alu_top uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_a            (a),
    .i_b            (b),
    .i_op           (op),
    .i_valid        (valid),
    .o_ready        (ready),
    .o_result       (result),
    .o_error        (error),
    .o_result_valid (result_valid),
    .i_result_ready (result_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Reference model in plain modulo-2^16 arithmetic
  function automatic logic [DATA_WIDTH-1:0] model_result(input logic [DATA_WIDTH-1:0] ma,
                                                         input logic [DATA_WIDTH-1:0] mb,
                                                         input logic [OP_WIDTH-1:0]   mop);
    case (mop)
      OP_ADD:  return ma + mb;
      OP_SUB:  return ma - mb;
      OP_MUL:  return ma * mb;                  // Low half only
      default: return (mb == '0) ? '0 : ma / mb;
    endcase
  endfunction

  // Cycles from acceptance to result valid
  function automatic int model_latency(input logic [OP_WIDTH-1:0]   mop,
                                       input logic [DATA_WIDTH-1:0] mb);
    if (mop == OP_ADD || mop == OP_SUB) return 2;
    if (mop == OP_DIV && mb == '0) return 1;   // Error skips the loop
    return DATA_WIDTH + 1;
  endfunction

  task automatic add_row(input logic [DATA_WIDTH-1:0] ra, input logic [DATA_WIDTH-1:0] rb,
                         input logic [OP_WIDTH-1:0] rop, input logic [DATA_WIDTH-1:0] rres,
                         input bit rerr, input int rlat, input int rhold);
    tab_a[row_count]       = ra;
    tab_b[row_count]       = rb;
    tab_op[row_count]      = rop;
    tab_result[row_count]  = rres;
    tab_error[row_count]   = rerr;
    tab_latency[row_count] = rlat;
    tab_hold[row_count]    = rhold;
    row_count++;
  endtask

  task automatic check_result(input string name, input logic [DATA_WIDTH-1:0] expected,
                              input logic [DATA_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_error(input string name, input bit expected, input logic actual);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input bit expected, input logic actual);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_latency(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
      errors++;
    end
  endtask

  // Runs one operation from falling edge to falling edge
  task automatic run_row(input int idx);
    int                    lat;
    int                    errors_before;
    logic [DATA_WIDTH-1:0] held_result;
    logic                  held_error;
    errors_before = errors;
    while (!ready) @(negedge clk);
    a     = tab_a[idx];
    b     = tab_b[idx];
    op    = tab_op[idx];
    valid = 1'b1;
    @(negedge clk);                    // Accepted on the edge just passed
    valid = 1'b0;
    a     = ~a;                        // Operands only matter at acceptance
    b     = ~b;
    lat   = 1;
    while (!result_valid) begin
      @(negedge clk);
      lat++;
    end
    check_latency("latency", tab_latency[idx], lat);
    check_result("o_result", tab_result[idx], result);
    check_error("o_error", tab_error[idx], error);
    held_result = result;
    held_error  = error;
    repeat (tab_hold[idx]) begin
      @(negedge clk);
      check_result("o_result", held_result, result);
      check_error("o_error", held_error, error);
      check_flag("o_ready", 1'b0, ready);
      check_flag("o_result_valid", 1'b1, result_valid);
    end
    result_ready = 1'b1;
    @(negedge clk);                    // Taken and back to idle
    result_ready = 1'b0;
    check_flag("o_ready", 1'b1, ready);
    check_flag("o_result_valid", 1'b0, result_valid);
    if (errors == errors_before) pass_count++;
    else fail_count++;
    $display("Row %0d op %0d a=%h b=%h result=%h latency=%0d: %s", idx, tab_op[idx],
             tab_a[idx], tab_b[idx], held_result, lat,
             (errors == errors_before) ? "ok" : "mismatch");
  endtask

  initial begin
    logic [DATA_WIDTH-1:0] ra;
    logic [DATA_WIDTH-1:0] rb;
    logic [OP_WIDTH-1:0]   rop;
    int                    rhold;
    clk          = 1'b0;
    rst_n        = 1'b0;
    a            = '0;
    b            = '0;
    op           = OP_ADD;
    valid        = 1'b0;
    result_ready = 1'b0;

    // Corner cases
    add_row(16'hFFFF, 16'h0001, OP_ADD, 16'h0000, 1'b0, 2, 0);
    add_row(16'h0000, 16'h0001, OP_SUB, 16'hFFFF, 1'b0, 2, 2);
    add_row(16'hFFFF, 16'hFFFF, OP_MUL, 16'h0001, 1'b0, 17, 0);
    add_row(16'd100, 16'd7, OP_DIV, 16'd14, 1'b0, 17, 3);
    add_row(16'd7, 16'd0, OP_DIV, 16'd0, 1'b1, 1, 2);      // Divide by zero after a nonzero result
    add_row(16'd5, 16'd9, OP_DIV, 16'd0, 1'b0, 17, 0);     // Dividend below divisor
    add_row(16'h1234, 16'h0000, OP_MUL, 16'h0000, 1'b0, 17, 1);
    add_row(16'hFFFF, 16'h0001, OP_DIV, 16'hFFFF, 1'b0, 17, 0);

    // Random rows with expected values from the model
    for (int i = FIXED_ROWS; i < NUM_ROWS; i++) begin
      ra    = $random(seed);
      rb    = $random(seed);
      rop   = $random(seed);
      rhold = {$random(seed)} % 4;
      if (rop == OP_DIV && i % 3 == 0) rb = rb >> 9;       // Small divisor for a big quotient
      if (rop == OP_DIV && i % 7 == 0) rb = '0;
      add_row(ra, rb, rop, model_result(ra, rb, rop), (rop == OP_DIV && rb == '0),
              model_latency(rop, rb), rhold);
    end

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Idle state straight out of reset
    check_flag("o_ready", 1'b1, ready);
    check_flag("o_result_valid", 1'b0, result_valid);
    check_error("o_error", 1'b0, error);
    check_result("o_result", '0, result);
    if (errors == 0) pass_count++;
    else fail_count++;
    $display("Reset state: %s", (errors == 0) ? "ok" : "mismatch");

    for (int i = 0; i < row_count; i++) run_row(i);

    $display("%0d passed, %0d failed, %0d assertion failures", pass_count, fail_count,
             uut.u_assert.violations);
    if (fail_count == 0 && uut.u_assert.violations == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog sized for every row plus reset
  initial begin
    #((NUM_ROWS * ROW_CYCLES + RESET_CYCLES) * CLK_PERIOD);
    $display("Run timed out, the DUT stopped answering the handshake");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/alu_assert.sv
// ALU handshake protocol assertions, bound into the top level
`timescale 1ns/100ps
`default_nettype none

module alu_assert (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           i_ready,
  input logic                           i_result_valid,
  input logic                           i_result_ready,
  input logic [alu_pkg::DATA_WIDTH-1:0] i_result,
  input logic                           i_error
);

  int unsigned violations = 0;  // Failed assertions so far

  // Input and output side never open at once
  a_ready_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(i_ready && i_result_valid))
    else begin
      $error("o_ready and o_result_valid high together");
      violations++;
    end

  // Offered result stays until taken
  a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (i_result_valid && !i_result_ready) |=> i_result_valid)
    else begin
      $error("o_result_valid dropped before the result was taken");
      violations++;
    end

  a_result_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (i_result_valid && !i_result_ready) |=> $stable(i_result))
    else begin
      $error("o_result changed under back-pressure");
      violations++;
    end

  a_error_valid: assert property (@(posedge clk) disable iff (!rst_n)
    i_error |-> i_result_valid)
    else begin
      $error("o_error high without o_result_valid");
      violations++;
    end

endmodule

bind alu_top alu_assert u_assert (
  .clk            (clk),
  .rst_n          (rst_n),
  .i_ready        (o_ready),
  .i_result_valid (o_result_valid),
  .i_result_ready (i_result_ready),
  .i_result       (o_result),
  .i_error        (o_error)
);

`default_nettype wire

//--- logic/alu_top.sv
// ALU top level, sequencer and datapath joined to the handshake ports
`timescale 1ns/100ps
`default_nettype none

module alu_top (
  input  logic                           clk,
  input  logic                           rst_n,

  // Operation in
  input  logic [alu_pkg::DATA_WIDTH-1:0] i_a,
  input  logic [alu_pkg::DATA_WIDTH-1:0] i_b,
  input  logic [alu_pkg::OP_WIDTH-1:0]   i_op,
  input  logic                           i_valid,
  output logic                           o_ready,

  // Result out
  output logic [alu_pkg::DATA_WIDTH-1:0] o_result,
  output logic                           o_error,         // Divide by zero
  output logic                           o_result_valid,
  input  logic                           i_result_ready
);

  // Step strobes, sequencer to datapath
  logic load;
  logic do_add;
  logic do_sub;
  logic mul_step;
  logic div_step;

  alu_sequencer u_sequencer (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_valid        (i_valid),
    .i_op           (i_op),
    .i_b            (i_b),
    .o_ready        (o_ready),
    .o_result_valid (o_result_valid),
    .o_error        (o_error),
    .i_result_ready (i_result_ready),
    .o_load         (load),
    .o_do_add       (do_add),
    .o_do_sub       (do_sub),
    .o_mul_step     (mul_step),
    .o_div_step     (div_step)
  );

  alu_datapath u_datapath (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_a        (i_a),
    .i_b        (i_b),
    .i_load     (load),
    .i_do_add   (do_add),
    .i_do_sub   (do_sub),
    .i_mul_step (mul_step),
    .i_div_step (div_step),
    .o_result   (o_result)
  );

endmodule

`default_nettype wire

//--- logic/alu_datapath.sv
// ALU datapath, operand and result registers around one shared adder
`timescale 1ns/100ps
`default_nettype none

module alu_datapath (
  input  logic                           clk,
  input  logic                           rst_n,

  input  logic [alu_pkg::DATA_WIDTH-1:0] i_a,
  input  logic [alu_pkg::DATA_WIDTH-1:0] i_b,

  input  logic                           i_load,      // Capture operands, clear result
  input  logic                           i_do_add,
  input  logic                           i_do_sub,
  input  logic                           i_mul_step,
  input  logic                           i_div_step,

  output logic [alu_pkg::DATA_WIDTH-1:0] o_result
);
  import alu_pkg::*;

  // Upper half of A is the division remainder
  logic [2*DATA_WIDTH-1:0] a_reg;
  logic [DATA_WIDTH-1:0]   b_reg;
  logic [DATA_WIDTH-1:0]   result_reg;

  // Shared adder
  logic [DATA_WIDTH-1:0] adder_a;
  logic [DATA_WIDTH-1:0] adder_b;
  logic                  adder_cin;
  logic [DATA_WIDTH:0]   adder_full;   // Carry in top bit
  logic [DATA_WIDTH-1:0] adder_sum;
  logic                  adder_carry;

  logic divides;  // Trial subtraction did not borrow

  assign adder_full = {1'b0, adder_a} + {1'b0, adder_b} + {{DATA_WIDTH{1'b0}}, adder_cin};
  assign adder_sum   = adder_full[DATA_WIDTH-1:0];
  assign adder_carry = adder_full[DATA_WIDTH];

  // Shifted remainder is 17 bits wide, top bit set means it always fits
  assign divides = adder_carry | a_reg[2*DATA_WIDTH-1];

  assign o_result = result_reg;

  // Adder input select
  always_comb begin
    adder_a   = '0;
    adder_b   = '0;
    adder_cin = 1'b0;
    if (i_do_add) begin
      adder_a = a_reg[DATA_WIDTH-1:0];
      adder_b = b_reg;
    end else if (i_do_sub) begin
      adder_a   = a_reg[DATA_WIDTH-1:0];
      adder_b   = ~b_reg;  // Two's complement, +1 via carry in
      adder_cin = 1'b1;
    end else if (i_mul_step) begin
      adder_a = result_reg;  // Partial product accumulate
      adder_b = b_reg;
    end else if (i_div_step) begin
      // Remainder shifted left by one, minus divisor
      adder_a   = a_reg[2*DATA_WIDTH-2:DATA_WIDTH-1];
      adder_b   = ~b_reg;
      adder_cin = 1'b1;
    end
  end

  // A register
  always_ff @(posedge clk) begin
    if (i_load) begin
      a_reg <= {{DATA_WIDTH{1'b0}}, i_a};  // Remainder starts at zero
    end else if (i_mul_step) begin
      a_reg[DATA_WIDTH-1:0] <= {1'b0, a_reg[DATA_WIDTH-1:1]};  // Next multiplier bit to LSB
    end else if (i_div_step) begin
      if (divides) begin
        // Keep the difference as new remainder
        a_reg <= {adder_sum, a_reg[DATA_WIDTH-2:0], 1'b0};
      end else begin
        a_reg <= {a_reg[2*DATA_WIDTH-2:0], 1'b0};  // Restore, shift only
      end
    end
  end

  // B register
  always_ff @(posedge clk) begin
    if (i_load) begin
      b_reg <= i_b;
    end else if (i_mul_step) begin
      b_reg <= {b_reg[DATA_WIDTH-2:0], 1'b0};  // Weight of next partial product
    end
  end

  // Result register
  // Cleared on reset and at acceptance, so divide by zero reads zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_reg <= '0;
    end else if (i_load) begin
      result_reg <= '0;
    end else if (i_do_add || i_do_sub) begin
      result_reg <= adder_sum;
    end else if (i_mul_step) begin
      if (a_reg[0]) begin
        result_reg <= adder_sum;  // Add only for a set multiplier bit
      end
    end else if (i_div_step) begin
      result_reg <= {result_reg[DATA_WIDTH-2:0], divides};  // Quotient bit in, MSB first
    end
  end

endmodule

`default_nettype wire

//--- logic/alu_sequencer.sv
// ALU sequencer, accepts operations, counts multi-cycle steps, drives the result handshake
`timescale 1ns/100ps
`default_nettype none

module alu_sequencer (
  input  logic                           clk,
  input  logic                           rst_n,

  input  logic                           i_valid,
  input  logic [alu_pkg::OP_WIDTH-1:0]   i_op,
  input  logic [alu_pkg::DATA_WIDTH-1:0] i_b,             // Divisor, zero test only
  output logic                           o_ready,

  output logic                           o_result_valid,
  output logic                           o_error,
  input  logic                           i_result_ready,

  output logic                           o_load,          // Accept this cycle
  output logic                           o_do_add,
  output logic                           o_do_sub,
  output logic                           o_mul_step,
  output logic                           o_div_step
);
  import alu_pkg::*;

  logic [STATE_WIDTH-1:0] state;
  logic [COUNT_WIDTH-1:0] count;   // Steps left in MUL/DIV
  logic                   b_zero;  // Divide by zero at acceptance

  assign b_zero = (i_b == '0);

  // Handshake levels, pure state decode
  assign o_ready        = (state == ST_WAIT);
  assign o_result_valid = (state == ST_RESULT) || (state == ST_ERROR);
  assign o_error        = (state == ST_ERROR);

  // Operation accepted
  assign o_load = o_ready && i_valid;

  // Datapath step strobes
  assign o_do_add   = (state == ST_ADD);
  assign o_do_sub   = (state == ST_SUB);
  assign o_mul_step = (state == ST_MUL);
  assign o_div_step = (state == ST_DIV);

  // State register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_WAIT;
    end else begin
      case (state)
        ST_WAIT: begin
          if (o_load) begin
            case (i_op)
              OP_ADD:  state <= ST_ADD;
              OP_SUB:  state <= ST_SUB;
              OP_MUL:  state <= ST_MUL;
              OP_DIV:  state <= b_zero ? ST_ERROR : ST_DIV;  // Error skips the loop
              default: state <= ST_WAIT;
            endcase
          end
        end

        // One adder pass, result written on leaving
        ST_ADD,
        ST_SUB: begin
          state <= ST_RESULT;
        end

        // Last of the DATA_WIDTH steps runs with count at 0
        ST_MUL,
        ST_DIV: begin
          if (count == '0) begin
            state <= ST_RESULT;
          end
        end

        // Hold until taken, back-pressure keeps everything frozen
        ST_RESULT,
        ST_ERROR: begin
          if (i_result_ready) begin
            state <= ST_WAIT;
          end
        end

        default: begin
          state <= ST_WAIT;  // Unused code
        end
      endcase
    end
  end

  // Step counter
  // Reloads in every state that is not stepping, so MUL/DIV start at 15
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (o_mul_step || o_div_step) begin
      count <= count - 1'b1;
    end else begin
      count <= COUNT_WIDTH'(DATA_WIDTH - 1);
    end
  end

endmodule

`default_nettype wire

//--- logic/alu_pkg.sv
// ALU shared widths, operation codes and sequencer state codes
`default_nettype none

package alu_pkg;

  // Operand and result width
  localparam int DATA_WIDTH  = 16;
  // Step counter, counts DATA_WIDTH-1 down to 0
  localparam int COUNT_WIDTH = 4;

  // Operation codes
  localparam int OP_WIDTH = 2;

  localparam logic [OP_WIDTH-1:0] OP_ADD = 2'd0;  // Sum, wraps
  localparam logic [OP_WIDTH-1:0] OP_SUB = 2'd1;  // Difference, wraps
  localparam logic [OP_WIDTH-1:0] OP_MUL = 2'd2;  // Low half of product
  localparam logic [OP_WIDTH-1:0] OP_DIV = 2'd3;  // Unsigned quotient

  // Sequencer states
  localparam int STATE_WIDTH = 3;

  localparam logic [STATE_WIDTH-1:0] ST_WAIT   = 3'd0;  // Idle, input ready
  localparam logic [STATE_WIDTH-1:0] ST_ADD    = 3'd1;  // Single add step
  localparam logic [STATE_WIDTH-1:0] ST_SUB    = 3'd2;  // Single subtract step
  localparam logic [STATE_WIDTH-1:0] ST_MUL    = 3'd3;  // Shift-and-add loop
  localparam logic [STATE_WIDTH-1:0] ST_DIV    = 3'd4;  // Restoring division loop
  localparam logic [STATE_WIDTH-1:0] ST_RESULT = 3'd5;  // Result offered
  localparam logic [STATE_WIDTH-1:0] ST_ERROR  = 3'd6;  // Divide by zero offered

  // Code 7 is unused, the sequencer falls back to ST_WAIT

endpackage

`default_nettype wire
